// File: Bender.yml
package:
  name: alu_iq

sources:
  - files:
      - hdl/iq_pkg.sv
      - hdl/iq_entry.sv
      - hdl/iq_alloc_ctrl.sv
      - hdl/iq_age_select.sv
      - hdl/iq_issue_reg.sv
      - hdl/alu_iq.sv
  - target: test
    files:
      - dv/alu_iq_tb.sv

// File: dv/alu_iq_tb.sv
`default_nettype none

module alu_iq_tb
    import iq_pkg::*;
();

    logic      clk;
    logic      rst;
    logic      dispatch_i;
    dispatch_t dispatch_data_i;
    wb_bus_t   wb_i;
    logic      full_o;
    logic      issue_valid_o;
    issue_t    issue_data_o;

    int          seed;
    int          drive_dly = 5;
    int unsigned n_rand_disp = 400;
    int unsigned timeout_cycles;
    int unsigned cycle_cnt;
    int unsigned disp_cnt;
    logic        compare_en;

    // expected outputs per cycle as {issue valid, full, issue data}
    logic [$bits(issue_t)+1:0] exp_q [$];

    // reference queue state
    logic        m_valid [IQ_DEPTH];
    logic        m_rdy1  [IQ_DEPTH];
    logic        m_rdy2  [IQ_DEPTH];
    int unsigned m_seq   [IQ_DEPTH];
    issue_t      m_item  [IQ_DEPTH];
    logic        m_iss_valid;
    issue_t      m_iss_data;
    int unsigned next_seq;

    alu_iq alu_iq_inst (
        .clk             (clk),
        .rst             (rst),
        .dispatch_i      (dispatch_i),
        .dispatch_data_i (dispatch_data_i),
        .wb_i            (wb_i),
        .full_o          (full_o),
        .issue_valid_o   (issue_valid_o),
        .issue_data_o    (issue_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp_v, act_v);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic tag_on_bus(input logic [PRF_W-1:0] tag, input wb_bus_t wb);
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb.port[p].valid && wb.port[p].tag == tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic model_full();
        foreach (m_valid[i]) begin
            if (!m_valid[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic model_empty();
        foreach (m_valid[i]) begin
            if (m_valid[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic void model_reset();
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
            m_rdy1[i]  = 1'b0;
            m_rdy2[i]  = 1'b0;
            m_seq[i]   = 0;
            m_item[i]  = '0;
        end
        m_iss_valid = 1'b0;
        m_iss_data  = '0;
        next_seq    = 0;
    endfunction

    // advance the queue one clock and return the outputs seen after the edge
    function automatic logic [$bits(issue_t)+1:0] model_step(input logic disp,
            input dispatch_t d, input wb_bus_t wb);
        int   pick;
        int   slot;
        logic older;
        pick = -1;
        slot = -1;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (m_valid[i] && m_rdy1[i] && m_rdy2[i]) begin
                older = 1'b0;
                for (int j = 0; j < IQ_DEPTH; j++) begin
                    if (m_valid[j] && m_seq[j] < m_seq[i]) older = 1'b1;
                end
                if (!(m_item[i].payload.is_special && older)) begin
                    if (pick < 0 || m_seq[i] < m_seq[pick]) pick = i;
                end
            end
        end
        if (disp && !model_full()) begin
            for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
                if (!m_valid[i]) slot = i;
            end
        end
        m_iss_valid = (pick >= 0);
        if (pick >= 0) begin
            m_iss_data    = m_item[pick];
            m_valid[pick] = 1'b0;
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (m_valid[i] && tag_on_bus(m_item[i].src1_tag, wb)) m_rdy1[i] = 1'b1;
            if (m_valid[i] && tag_on_bus(m_item[i].src2_tag, wb)) m_rdy2[i] = 1'b1;
        end
        if (slot >= 0) begin
            m_valid[slot]          = 1'b1;
            m_seq[slot]            = next_seq;
            next_seq++;
            m_item[slot].payload   = d.payload;
            m_item[slot].src1_tag  = d.src1.tag;
            m_item[slot].src2_tag  = d.src2.tag;
            m_rdy1[slot] = !d.src1.rd_en || d.src1.rdy || tag_on_bus(d.src1.tag, wb);
            m_rdy2[slot] = !d.src2.rd_en || d.src2.rdy || tag_on_bus(d.src2.tag, wb);
        end
        return {m_iss_valid, model_full(), m_iss_data};
    endfunction

    function automatic dispatch_t rand_disp();
        logic [127:0] r;
        dispatch_t    d;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        d = r[$bits(dispatch_t)-1:0];
        d.payload.is_special = 1'b0;
        d.src1.tag   = PRF_W'(r[102:99]); // small tag range so wakeups hit
        d.src1.rd_en = r[103] | r[104];
        d.src1.rdy   = r[105];
        d.src2.tag   = PRF_W'(r[109:106]);
        d.src2.rd_en = r[110] | r[111];
        d.src2.rdy   = r[112];
        return d;
    endfunction

    function automatic dispatch_t waiting_on(input logic [PRF_W-1:0] tag);
        dispatch_t d;
        d = rand_disp();
        d.src1 = '{tag: tag, rd_en: 1'b1, rdy: 1'b0};
        d.src2.rd_en = 1'b0;
        return d;
    endfunction

    function automatic wb_bus_t wb_one(input logic [PRF_W-1:0] tag, input logic vld);
        wb_bus_t w;
        w = '0;
        w.port[0].valid = vld;
        w.port[0].tag   = tag;
        return w;
    endfunction

    function automatic wb_bus_t rand_wb();
        wb_bus_t w;
        for (int p = 0; p < WB_PORTS; p++) begin
            w.port[p].valid = ($random(seed) & 3) != 0;
            w.port[p].tag   = PRF_W'($random(seed) & 15);
        end
        return w;
    endfunction

    task automatic drive_cycle(input logic disp, input dispatch_t d, input wb_bus_t wb);
        logic go;
        go = disp && !model_full();
        dispatch_i      = go;
        dispatch_data_i = d;
        wb_i            = wb;
        if (go) disp_cnt++;
        exp_q.push_back(model_step(go, d, wb));
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0);
    endtask

    // sweep every tag over the wb ports until the queue is empty
    task automatic drain();
        wb_bus_t w;
        int      base;
        base = 0;
        while (!model_empty() || m_iss_valid) begin
            for (int p = 0; p < WB_PORTS; p++) begin
                w.port[p].valid = 1'b1;
                w.port[p].tag   = PRF_W'(base + p);
            end
            base = (base + WB_PORTS) % (2 ** PRF_W);
            drive_cycle(1'b0, '0, w);
        end
        idle(2);
    endtask

    initial begin : compare_proc
        logic [$bits(issue_t)+1:0] e;
        forever begin
            @(negedge clk);
            if (compare_en) begin
                if (exp_q.size() == 0) begin
                    $display("compare process found no expected value for this cycle");
                    $display("CHECKS FAILED");
                    $fatal(1);
                end else begin
                    e = exp_q.pop_front();
                    check_val("issue_valid_o", e[$bits(issue_t)+1], issue_valid_o);
                    check_val("full_o", e[$bits(issue_t)], full_o);
                    if (e[$bits(issue_t)+1]) begin
                        check_val("issue_data_o", e[$bits(issue_t)-1:0], issue_data_o);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt++;
            if (cycle_cnt > timeout_cycles) begin
                $display("timeout: run took more than %0d cycles", timeout_cycles);
                $display("CHECKS FAILED");
                $fatal(1);
            end
        end
    end

    initial begin : stimulus
        dispatch_t   d;
        wb_bus_t     w;
        int unsigned stop_at;
        seed            = 32'hef24_8d8d;
        rst             = 1'b1;
        dispatch_i      = 1'b0;
        dispatch_data_i = '0;
        wb_i            = '0;
        compare_en      = 1'b0;
        cycle_cnt       = 0;
        disp_cnt        = 0;
        // directed part plus worst case random rate plus drain sweep
        timeout_cycles  = 200 + 6 * n_rand_disp + 64;
        model_reset();
        repeat (4) @(posedge clk);
        #drive_dly;
        rst = 1'b0;
        exp_q.push_back('0);
        compare_en = 1'b1;

        // sources unused or ready at rename
        d = rand_disp();
        d.src1.rd_en = 1'b0;
        d.src2 = '{tag: 6'd7, rd_en: 1'b1, rdy: 1'b1};
        drive_cycle(1'b1, d, '0);
        idle(3);

        // wakeup while waiting and a tag without valid ignored
        drive_cycle(1'b1, waiting_on(6'd10), '0);
        idle(1);
        drive_cycle(1'b0, '0, wb_one(6'd10, 1'b0));
        idle(2);
        drive_cycle(1'b0, '0, wb_one(6'd10, 1'b1));
        idle(3);
        drive_cycle(1'b1, waiting_on(6'd20), wb_one(6'd20, 1'b1)); // bypass at dispatch
        idle(3);

        // age order with a same cycle wakeup
        for (int k = 0; k < 4; k++) drive_cycle(1'b1, waiting_on(6'd30), '0);
        drive_cycle(1'b0, '0, wb_one(6'd30, 1'b1));
        idle(6);

        // free slots 2 and 3 first, refill them, then wake all
        for (int k = 0; k < 5; k++) drive_cycle(1'b1, waiting_on(PRF_W'(40 + k)), '0);
        w = '0;
        w.port[0] = '{valid: 1'b1, tag: 6'd42};
        w.port[1] = '{valid: 1'b1, tag: 6'd43};
        drive_cycle(1'b0, '0, w);
        idle(3);
        for (int k = 0; k < 2; k++) drive_cycle(1'b1, waiting_on(6'd45), '0);
        w.port[0] = '{valid: 1'b1, tag: 6'd40};
        w.port[1] = '{valid: 1'b1, tag: 6'd41};
        w.port[2] = '{valid: 1'b1, tag: 6'd44};
        w.port[3] = '{valid: 1'b1, tag: 6'd45};
        drive_cycle(1'b0, '0, w);
        idle(8);

        // special behind an older waiting entry
        drive_cycle(1'b1, waiting_on(6'd50), '0);
        d = rand_disp();
        d.src1.rd_en = 1'b0;
        d.src2.rd_en = 1'b0;
        d.payload.is_special = 1'b1;
        drive_cycle(1'b1, d, '0);
        idle(4);
        drive_cycle(1'b0, '0, wb_one(6'd50, 1'b1));
        idle(4);

        // fill up, then release everything
        for (int k = 0; k < IQ_DEPTH; k++) drive_cycle(1'b1, waiting_on(6'd60), '0);
        check_val("full_o", 1'b1, full_o);
        idle(2);
        drive_cycle(1'b0, '0, wb_one(6'd60, 1'b1));
        idle(IQ_DEPTH + 3);

        stop_at = disp_cnt + n_rand_disp;
        while (disp_cnt < stop_at) begin
            d = rand_disp();
            d.payload.is_special = ($random(seed) & 7) == 0;
            drive_cycle(($random(seed) & 3) != 0, d, rand_wb());
        end
        drain();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/alu_iq.sv
`default_nettype none

module alu_iq
    import iq_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      dispatch_i,
    input  wire dispatch_t dispatch_data_i,
    input  wire wb_bus_t   wb_i,
    output logic           full_o,
    output logic           issue_valid_o,
    output issue_t         issue_data_o
);

    logic [IQ_DEPTH-1:0] valid_vec;
    logic [IQ_DEPTH-1:0] rdy_vec;
    logic [IQ_DEPTH-1:0] special_vec;
    logic [IQ_DEPTH-1:0] entry_wen;
    logic [IQ_DEPTH-1:0] grant;

    alu_payload_t     entry_payload [IQ_DEPTH];
    logic [PRF_W-1:0] entry_src1    [IQ_DEPTH];
    logic [PRF_W-1:0] entry_src2    [IQ_DEPTH];
    issue_t           entry_issue   [IQ_DEPTH];

    iq_alloc_ctrl alloc_inst (
        .clk         (clk),
        .rst         (rst),
        .dispatch_i  (dispatch_i),
        .valid_vec_i (valid_vec),
        .entry_wen_o (entry_wen),
        .full_o      (full_o)
    );

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        iq_entry #(
            .payload_t (alu_payload_t)
        ) entry_inst (
            .clk        (clk),
            .rst        (rst),
            .wen_i      (entry_wen[i]),
            .grant_i    (grant[i]),
            .disp_i     (dispatch_data_i),
            .wb_i       (wb_i),
            .valid_o    (valid_vec[i]),
            .rdy_o      (rdy_vec[i]),
            .payload_o  (entry_payload[i]),
            .src1_tag_o (entry_src1[i]),
            .src2_tag_o (entry_src2[i])
        );

        assign special_vec[i]          = entry_payload[i].is_special;
        assign entry_issue[i].payload  = entry_payload[i];
        assign entry_issue[i].src1_tag = entry_src1[i];
        assign entry_issue[i].src2_tag = entry_src2[i];
    end

    iq_age_select select_inst (
        .clk           (clk),
        .rst           (rst),
        .entry_wen_i   (entry_wen),
        .valid_vec_i   (valid_vec),
        .rdy_vec_i     (rdy_vec),
        .special_vec_i (special_vec),
        .grant_o       (grant)
    );

    iq_issue_reg #(
        .payload_t (issue_t)
    ) issue_inst (
        .clk             (clk),
        .rst             (rst),
        .grant_i         (grant),
        .payload_vec_i   (entry_issue),
        .issue_valid_o   (issue_valid_o),
        .issue_payload_o (issue_data_o)
    );

endmodule

`default_nettype wire

// File: hdl/iq_age_select.sv
`default_nettype none

module iq_age_select
    import iq_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [IQ_DEPTH-1:0] entry_wen_i,
    input  wire logic [IQ_DEPTH-1:0] valid_vec_i,
    input  wire logic [IQ_DEPTH-1:0] rdy_vec_i,
    input  wire logic [IQ_DEPTH-1:0] special_vec_i,
    output logic      [IQ_DEPTH-1:0] grant_o
);

    // older_q[i][j] set when entry j is older than entry i
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older_q;

    logic [IQ_DEPTH-1:0] older_valid;
    logic [IQ_DEPTH-1:0] eligible;

    always_ff @(posedge clk) begin
        if (rst) begin
            older_q <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (entry_wen_i[i]) begin
                    older_q[i] <= valid_vec_i; // everyone live is older
                end else begin
                    for (int j = 0; j < IQ_DEPTH; j++) begin
                        if (entry_wen_i[j]) begin
                            older_q[i][j] <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            older_valid[i] = |(older_q[i] & valid_vec_i);
        end
    end

    // special ops wait until they head the queue
    assign eligible = rdy_vec_i & (~special_vec_i | ~older_valid);

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            grant_o[i] = eligible[i] && !(|(older_q[i] & eligible));
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant_o));

    // something ready always gets picked
    grant_progress: assert property (@(posedge clk) disable iff (rst)
        (|eligible) |-> (|grant_o));

endmodule

`default_nettype wire

// File: hdl/iq_alloc_ctrl.sv
`default_nettype none

module iq_alloc_ctrl
    import iq_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                dispatch_i,
    input  wire logic [IQ_DEPTH-1:0] valid_vec_i,
    output logic      [IQ_DEPTH-1:0] entry_wen_o,
    output logic                     full_o
);

    logic [IQ_DEPTH-1:0] free_vec;
    logic [IQ_IDX_W-1:0] free_idx;

    assign free_vec = ~valid_vec_i;
    assign full_o   = &valid_vec_i;

    // lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                free_idx = IQ_IDX_W'(i);
            end
        end
    end

    always_comb begin
        entry_wen_o           = '0;
        entry_wen_o[free_idx] = dispatch_i && !full_o;
    end

    // rename has to stall on full
    no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        !(dispatch_i && full_o));

    wen_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(entry_wen_o));

endmodule

`default_nettype wire

// File: hdl/iq_entry.sv
`default_nettype none

module iq_entry
    import iq_pkg::*;
#(
    parameter type payload_t = alu_payload_t
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wen_i,
    input  wire logic             grant_i,
    input  wire dispatch_t        disp_i,
    input  wire wb_bus_t          wb_i,
    output logic                  valid_o,
    output logic                  rdy_o,
    output payload_t              payload_o,
    output logic [PRF_W-1:0]      src1_tag_o,
    output logic [PRF_W-1:0]      src2_tag_o
);

    logic             valid_q;
    logic             rs1_rdy_q;
    logic             rs2_rdy_q;
    payload_t         payload_q;
    logic [PRF_W-1:0] rs1_tag_q;
    logic [PRF_W-1:0] rs2_tag_q;

    logic rs1_rdy_entry;
    logic rs2_rdy_entry;
    logic rs1_wake;
    logic rs2_wake;

    // any valid writeback port carrying this tag
    function automatic logic wb_hit(input logic [PRF_W-1:0] tag, input wb_bus_t wb);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            hit |= wb.port[p].valid && (wb.port[p].tag == tag);
        end
        return hit;
    endfunction

    // ready on entry: unused, flagged by rename, or bypassed this cycle
    assign rs1_rdy_entry = !disp_i.src1.rd_en || disp_i.src1.rdy
                           || wb_hit(disp_i.src1.tag, wb_i);
    assign rs2_rdy_entry = !disp_i.src2.rd_en || disp_i.src2.rdy
                           || wb_hit(disp_i.src2.tag, wb_i);

    assign rs1_wake = valid_q && wb_hit(rs1_tag_q, wb_i);
    assign rs2_wake = valid_q && wb_hit(rs2_tag_q, wb_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (wen_i) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (wen_i) begin
            rs1_rdy_q <= rs1_rdy_entry;
            rs2_rdy_q <= rs2_rdy_entry;
        end else if (grant_i) begin
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else begin
            if (rs1_wake) rs1_rdy_q <= 1'b1;
            if (rs2_wake) rs2_rdy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wen_i) begin
            payload_q <= disp_i.payload;
            rs1_tag_q <= disp_i.src1.tag;
            rs2_tag_q <= disp_i.src2.tag;
        end
    end

    assign valid_o    = valid_q;
    assign rdy_o      = valid_q && rs1_rdy_q && rs2_rdy_q;
    assign payload_o  = payload_q;
    assign src1_tag_o = rs1_tag_q;
    assign src2_tag_o = rs2_tag_q;

    // selector must only pick live entries
    grant_on_valid: assert property (@(posedge clk) disable iff (rst)
        grant_i |-> valid_q);

endmodule

`default_nettype wire

// File: hdl/iq_issue_reg.sv
`default_nettype none

module iq_issue_reg
    import iq_pkg::*;
#(
    parameter type payload_t = issue_t
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [IQ_DEPTH-1:0] grant_i,
    input  wire payload_t            payload_vec_i [IQ_DEPTH],
    output logic                     issue_valid_o,
    output payload_t                 issue_payload_o
);

    payload_t sel_payload;

    // and-or mux, grant is one-hot
    always_comb begin
        sel_payload = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            sel_payload = sel_payload
                          | ({$bits(payload_t){grant_i[i]}} & payload_vec_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= |grant_i;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant_i) begin
            issue_payload_o <= sel_payload;
        end
    end

endmodule

`default_nettype wire

// File: hdl/iq_pkg.sv
`default_nettype none

package iq_pkg;

    localparam int IQ_DEPTH = 8;
    localparam int IQ_IDX_W = 3;
    localparam int PRF_W    = 6;
    localparam int ALU_OP_W = 4;
    localparam int WB_PORTS = 4;

    // carried through the queue untouched
    typedef struct packed {
        logic [31:0]         pc;
        logic [PRF_W-1:0]    prf_rd;
        logic [PRF_W-1:0]    prf_rd_stale;
        logic                wen_rd;
        logic [31:0]         imm;
        logic [ALU_OP_W-1:0] alu_op;
        logic                is_ds;      // delay slot
        logic                is_special; // cp0 and friends, issue alone
    } alu_payload_t;

    typedef struct packed {
        logic [PRF_W-1:0] tag;
        logic             rd_en; // source actually read
        logic             rdy;   // ready at rename time
    } src_t;

    typedef struct packed {
        alu_payload_t payload;
        src_t         src1;
        src_t         src2;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [PRF_W-1:0] tag;
    } wb_port_t;

    typedef struct packed {
        wb_port_t [WB_PORTS-1:0] port;
    } wb_bus_t;

    // tags go along for the regfile read
    typedef struct packed {
        alu_payload_t     payload;
        logic [PRF_W-1:0] src1_tag;
        logic [PRF_W-1:0] src2_tag;
    } issue_t;

endpackage

`default_nettype wire

// File: list.f
hdl/iq_pkg.sv
hdl/iq_entry.sv
hdl/iq_alloc_ctrl.sv
hdl/iq_age_select.sv
hdl/iq_issue_reg.sv
hdl/alu_iq.sv
dv/alu_iq_tb.sv
